// ==== sdram_sched_cfg.svh ====
////////////////////
// Compile-time settings for the single-port SDRAM command scheduler
// Widths, burst length and all timing values in clock cycles
// Included by the package, every RTL file and the testbench
////////////////////

`ifndef SDRAM_SCHED_CFG_SVH
`define SDRAM_SCHED_CFG_SVH

// Address and data widths
`define SDRAM_BA_W      2
`define SDRAM_ROW_W     11
`define SDRAM_COL_W     8
`define SDRAM_DQ_W      16
`define SDRAM_BURST_LEN 4

// Device timings in cycles
`define SDRAM_CL        2
`define SDRAM_T_RCD     2
`define SDRAM_T_RP      2
`define SDRAM_T_RAS     5
`define SDRAM_T_WR      2
`define SDRAM_T_RFC     7
`define SDRAM_T_REFI    300

// Width shared by all timing down-counters
`define SDRAM_TIMER_W   4

`endif

// ==== sdram_sched_pkg.sv ====
////////////////////
// Types shared by the SDRAM scheduler blocks
// Vector widths come from the config header
////////////////////

`include "sdram_sched_cfg.svh"

package sdram_sched_pkg;

  typedef logic [`SDRAM_BA_W-1:0]                  ba_t;
  typedef logic [`SDRAM_ROW_W-1:0]                 row_t;
  typedef logic [`SDRAM_COL_W-1:0]                 col_t;
  typedef logic [`SDRAM_DQ_W-1:0]                  dq_t;
  // Word 0 sits in the low bits
  typedef logic [`SDRAM_BURST_LEN*`SDRAM_DQ_W-1:0] burst_t;
  // Bit 10 selects all banks on PRE
  typedef logic [`SDRAM_ROW_W-1:0]                 sdram_addr_t;
  typedef logic [`SDRAM_TIMER_W-1:0]               tcnt_t;

  // Encoded as {cs_n, ras_n, cas_n, we_n}
  typedef enum logic [3:0] {
    CMD_NOP = 4'b0111,
    CMD_ACT = 4'b0011,
    CMD_RD  = 4'b0101,
    CMD_WR  = 4'b0100,
    CMD_PRE = 4'b0010,
    CMD_REF = 4'b0001
  } sdram_cmd_e;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_PRE_ALL,
    ST_REF
  } sched_state_e;

endpackage

// ==== sdram_bank_timers.sv ====
////////////////////
// Timing counters for the SDRAM scheduler
// Per bank tRCD, tRP and tRAS/tWR, plus tRFC and burst busy
// A counter loads when its command is decided and its done flag
// is set while the count is zero
////////////////////

`timescale 1ns/1ns
`include "sdram_sched_cfg.svh"

module sdram_bank_timers (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          act_i,
  input  logic                          pre_i,
  input  logic                          pre_all_i,
  input  logic                          ref_i,
  input  logic                          rd_i,
  input  logic                          wr_i,
  input  sdram_sched_pkg::ba_t          cmd_ba_i,
  output logic [(1 << `SDRAM_BA_W)-1:0] rcd_done_o,
  output logic [(1 << `SDRAM_BA_W)-1:0] rp_done_o,
  output logic [(1 << `SDRAM_BA_W)-1:0] ras_done_o,
  output logic                          rfc_done_o,
  output logic                          burst_done_o
);

  localparam int BANKS = 1 << `SDRAM_BA_W;

  // Load values are one less than the command spacing
  localparam sdram_sched_pkg::tcnt_t RCD_LD  = sdram_sched_pkg::tcnt_t'(`SDRAM_T_RCD - 1);
  localparam sdram_sched_pkg::tcnt_t RP_LD   = sdram_sched_pkg::tcnt_t'(`SDRAM_T_RP - 1);
  localparam sdram_sched_pkg::tcnt_t RAS_LD  = sdram_sched_pkg::tcnt_t'(`SDRAM_T_RAS - 1);
  localparam sdram_sched_pkg::tcnt_t RFC_LD  = sdram_sched_pkg::tcnt_t'(`SDRAM_T_RFC - 1);
  // Last write word plus write recovery
  localparam sdram_sched_pkg::tcnt_t WREC_LD =
    sdram_sched_pkg::tcnt_t'(`SDRAM_BURST_LEN + `SDRAM_T_WR - 1);
  // Read data still returns CL cycles after the command
  localparam sdram_sched_pkg::tcnt_t RD_BUSY_LD =
    sdram_sched_pkg::tcnt_t'(`SDRAM_CL + `SDRAM_BURST_LEN - 1);
  localparam sdram_sched_pkg::tcnt_t WR_BUSY_LD =
    sdram_sched_pkg::tcnt_t'(`SDRAM_BURST_LEN - 1);

  sdram_sched_pkg::tcnt_t rfc_cnt;
  sdram_sched_pkg::tcnt_t burst_cnt;

  // Load wins, else count down and stop at zero
  function automatic sdram_sched_pkg::tcnt_t cnt_next(input sdram_sched_pkg::tcnt_t cnt,
                                                      input logic                   load,
                                                      input sdram_sched_pkg::tcnt_t val);
    if (load)
      return val;
    if (cnt != '0)
      return cnt - 1'b1;
    return cnt;
  endfunction

  ////////////////////
  // Per-bank counters
  ////////////////////
  for (genvar b = 0; b < BANKS; b++)
  begin : gen_bank
    logic                   bank_sel;
    sdram_sched_pkg::tcnt_t rcd_cnt;
    sdram_sched_pkg::tcnt_t rp_cnt;
    sdram_sched_pkg::tcnt_t ras_cnt;
    sdram_sched_pkg::tcnt_t wrec_val;

    assign bank_sel = cmd_ba_i == sdram_sched_pkg::ba_t'(b);
    // A write only ever extends the window to PRE
    assign wrec_val = (WREC_LD > ras_cnt) ? WREC_LD : ras_cnt;

    always_ff @(posedge clk_i or negedge rst_ni)
    begin
      if (!rst_ni)
      begin
        rcd_cnt <= '0;
        rp_cnt  <= '0;
        ras_cnt <= '0;
      end
      else
      begin
        rcd_cnt <= cnt_next(rcd_cnt, act_i & bank_sel, RCD_LD);
        rp_cnt  <= cnt_next(rp_cnt, (pre_i & bank_sel) | pre_all_i, RP_LD);
        ras_cnt <= cnt_next(ras_cnt, (act_i | wr_i) & bank_sel, act_i ? RAS_LD : wrec_val);
      end
    end

    assign rcd_done_o[b] = rcd_cnt == '0;
    assign rp_done_o[b]  = rp_cnt == '0;
    assign ras_done_o[b] = ras_cnt == '0;
  end

  ////////////////////
  // Global counters
  ////////////////////
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      rfc_cnt   <= '0;
      burst_cnt <= '0;
    end
    else
    begin
      rfc_cnt   <= cnt_next(rfc_cnt, ref_i, RFC_LD);
      burst_cnt <= cnt_next(burst_cnt, rd_i | wr_i, rd_i ? RD_BUSY_LD : WR_BUSY_LD);
    end
  end

  assign rfc_done_o   = rfc_cnt == '0;
  assign burst_done_o = burst_cnt == '0;

endmodule

// ==== sdram_bank_table.sv ====
////////////////////
// Open-row table for the SDRAM scheduler
// Tracks which bank is open and on which row, and decodes the
// status of the bank the client asks for
////////////////////

`timescale 1ns/1ns
`include "sdram_sched_cfg.svh"

module sdram_bank_table (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  act_i,
  input  logic                  pre_i,
  input  logic                  pre_all_i,
  input  sdram_sched_pkg::ba_t  cmd_ba_i,
  input  sdram_sched_pkg::row_t cmd_row_i,
  input  sdram_sched_pkg::ba_t  req_ba_i,
  input  sdram_sched_pkg::row_t req_row_i,
  output logic                  row_hit_o,
  output logic                  bank_idle_o,
  output logic                  all_idle_o
);

  localparam int BANKS = 1 << `SDRAM_BA_W;

  logic [BANKS-1:0]      bank_open;
  sdram_sched_pkg::row_t open_row [BANKS];

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      bank_open <= '0;
    else if (pre_all_i)
      bank_open <= '0;
    else if (pre_i)
      bank_open[cmd_ba_i] <= 1'b0;
    else if (act_i)
      bank_open[cmd_ba_i] <= 1'b1;
  end

  // Row is only valid while the open flag is set
  always_ff @(posedge clk_i)
  begin
    if (act_i)
      open_row[cmd_ba_i] <= cmd_row_i;
  end

  assign row_hit_o   = bank_open[req_ba_i] && (open_row[req_ba_i] == req_row_i);
  assign bank_idle_o = ~bank_open[req_ba_i];
  assign all_idle_o  = ~|bank_open;

endmodule

// ==== sdram_refresh_timer.sv ====
////////////////////
// Auto-refresh interval timer
// Counts owed refreshes, one per T_REFI, and pays one back per REF
////////////////////

`timescale 1ns/1ns
`include "sdram_sched_cfg.svh"

module sdram_refresh_timer (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic ref_issued_i,
  output logic refresh_pending_o
);

  localparam int REFI_W = $clog2(`SDRAM_T_REFI);

  logic [REFI_W-1:0] refi_cnt;
  logic              refi_expired;
  logic [2:0]        pending;

  assign refi_expired = refi_cnt == '0;

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      refi_cnt <= REFI_W'(`SDRAM_T_REFI - 1);
    else if (refi_expired)
      refi_cnt <= REFI_W'(`SDRAM_T_REFI - 1);
    else
      refi_cnt <= refi_cnt - 1'b1;
  end

  // Saturates at both ends
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      pending <= '0;
    else
    begin
      case ({refi_expired, ref_issued_i})
        2'b10: if (pending != '1) pending <= pending + 1'b1;
        2'b01: if (pending != '0) pending <= pending - 1'b1;
        default: ;
      endcase
    end
  end

  assign refresh_pending_o = |pending;

endmodule

// ==== sdram_sched_fsm.sv ====
////////////////////
// Command FSM of the SDRAM scheduler
// Picks REF, PRE, ACT, RD or WR each cycle and registers the command
// Load strobes leave with the decision so that timers and the bank
// table update on the edge that puts the command on the bus
////////////////////

`timescale 1ns/1ns
`include "sdram_sched_cfg.svh"

module sdram_sched_fsm (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          rd_req_i,
  input  logic                          wr_req_i,
  input  sdram_sched_pkg::ba_t          req_ba_i,
  input  sdram_sched_pkg::row_t         req_row_i,
  input  sdram_sched_pkg::col_t         req_col_i,
  input  logic                          row_hit_i,
  input  logic                          bank_idle_i,
  input  logic                          all_idle_i,
  input  logic [(1 << `SDRAM_BA_W)-1:0] rcd_done_i,
  input  logic [(1 << `SDRAM_BA_W)-1:0] rp_done_i,
  input  logic [(1 << `SDRAM_BA_W)-1:0] ras_done_i,
  input  logic                          rfc_done_i,
  input  logic                          burst_done_i,
  input  logic                          refresh_pending_i,
  output logic                          act_o,
  output logic                          pre_o,
  output logic                          pre_all_o,
  output logic                          ref_o,
  output logic                          rd_o,
  output logic                          wr_o,
  output sdram_sched_pkg::ba_t          cmd_ba_o,
  output logic                          rd_rdy_o,
  output logic                          wr_rdy_o,
  output sdram_sched_pkg::sdram_cmd_e   sdram_cmd_o,
  output sdram_sched_pkg::ba_t          sdram_ba_o,
  output sdram_sched_pkg::sdram_addr_t  sdram_addr_o
);

  sdram_sched_pkg::sched_state_e state;
  sdram_sched_pkg::sched_state_e state_nxt;
  sdram_sched_pkg::sdram_cmd_e   cmd_nxt;
  sdram_sched_pkg::ba_t          ba_nxt;
  sdram_sched_pkg::sdram_addr_t  addr_nxt;
  logic                          req_valid;

  // Request is still high during its ready pulse
  assign req_valid = (rd_req_i | wr_req_i) & ~rd_rdy_o & ~wr_rdy_o;

  ////////////////////
  // Next command
  ////////////////////
  always_comb
  begin
    state_nxt = state;
    cmd_nxt   = sdram_sched_pkg::CMD_NOP;
    ba_nxt    = sdram_ba_o;
    addr_nxt  = sdram_addr_o;

    case (state)
      sdram_sched_pkg::ST_IDLE:
        if (refresh_pending_i)
        begin
          // Refresh first, banks must be closed
          if (all_idle_i && &rp_done_i && rfc_done_i && burst_done_i)
            cmd_nxt = sdram_sched_pkg::CMD_REF;
          else if (!all_idle_i && &ras_done_i && rfc_done_i && burst_done_i)
          begin
            cmd_nxt      = sdram_sched_pkg::CMD_PRE;
            addr_nxt     = '0;
            addr_nxt[10] = 1'b1;
            state_nxt    = sdram_sched_pkg::ST_PRE_ALL;
          end
        end
        else if (req_valid)
        begin
          if (row_hit_i)
          begin
            if (rcd_done_i[req_ba_i] && burst_done_i)
            begin
              // Read wins over write
              cmd_nxt  = rd_req_i ? sdram_sched_pkg::CMD_RD : sdram_sched_pkg::CMD_WR;
              ba_nxt   = req_ba_i;
              addr_nxt = sdram_sched_pkg::sdram_addr_t'(req_col_i);
            end
          end
          else if (bank_idle_i)
          begin
            if (rp_done_i[req_ba_i] && rfc_done_i)
            begin
              cmd_nxt  = sdram_sched_pkg::CMD_ACT;
              ba_nxt   = req_ba_i;
              addr_nxt = req_row_i;
            end
          end
          // Bank open on another row
          else if (ras_done_i[req_ba_i] && burst_done_i)
          begin
            cmd_nxt  = sdram_sched_pkg::CMD_PRE;
            ba_nxt   = req_ba_i;
            addr_nxt = '0;
          end
        end

      // PRE-all is on the bus now
      sdram_sched_pkg::ST_PRE_ALL:
        state_nxt = sdram_sched_pkg::ST_REF;

      sdram_sched_pkg::ST_REF:
        if (&rp_done_i && rfc_done_i)
        begin
          cmd_nxt   = sdram_sched_pkg::CMD_REF;
          state_nxt = sdram_sched_pkg::ST_IDLE;
        end

      default:
        state_nxt = sdram_sched_pkg::ST_IDLE;
    endcase
  end

  // Strobes to timers, bank table and data path
  assign act_o     = cmd_nxt == sdram_sched_pkg::CMD_ACT;
  assign pre_o     = (cmd_nxt == sdram_sched_pkg::CMD_PRE) & ~addr_nxt[10];
  assign pre_all_o = (cmd_nxt == sdram_sched_pkg::CMD_PRE) & addr_nxt[10];
  assign ref_o     = cmd_nxt == sdram_sched_pkg::CMD_REF;
  assign rd_o      = cmd_nxt == sdram_sched_pkg::CMD_RD;
  assign wr_o      = cmd_nxt == sdram_sched_pkg::CMD_WR;
  assign cmd_ba_o  = ba_nxt;

  ////////////////////
  // Registered outputs
  ////////////////////
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      state       <= sdram_sched_pkg::ST_IDLE;
      sdram_cmd_o <= sdram_sched_pkg::CMD_NOP;
      rd_rdy_o    <= 1'b0;
      wr_rdy_o    <= 1'b0;
    end
    else
    begin
      state       <= state_nxt;
      sdram_cmd_o <= cmd_nxt;
      rd_rdy_o    <= rd_o;
      wr_rdy_o    <= wr_o;
    end
  end

  always_ff @(posedge clk_i)
  begin
    sdram_ba_o   <= ba_nxt;
    sdram_addr_o <= addr_nxt;
  end

endmodule

// ==== sdram_data_path.sv ====
////////////////////
// DQ handling for the SDRAM scheduler
// Writes shift the burst out one word per cycle from the WR cycle
// Reads open a valid window CL cycles after the RD cycle
////////////////////

`timescale 1ns/1ns
`include "sdram_sched_cfg.svh"

module sdram_data_path (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    rd_i,
  input  logic                    wr_i,
  input  sdram_sched_pkg::burst_t wr_data_i,
  input  sdram_sched_pkg::dq_t    sdram_dq_i,
  output sdram_sched_pkg::dq_t    sdram_dq_o,
  output logic                    sdram_dqoe_o,
  output sdram_sched_pkg::dq_t    rd_data_o,
  output logic                    rd_valid_o
);

  localparam int BCNT_W = $clog2(`SDRAM_BURST_LEN) + 1;

  sdram_sched_pkg::burst_t wr_buf;
  logic [BCNT_W-1:0]       wr_cnt;
  logic [`SDRAM_CL-1:0]    rd_dly;
  logic [BCNT_W-1:0]       rd_cnt;

  // Word 0 leaves first
  always_ff @(posedge clk_i)
  begin
    if (wr_i)
      wr_buf <= wr_data_i;
    else
      wr_buf <= wr_buf >> `SDRAM_DQ_W;
  end

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      wr_cnt <= '0;
      rd_dly <= '0;
      rd_cnt <= '0;
    end
    else
    begin
      if (wr_i)
        wr_cnt <= BCNT_W'(`SDRAM_BURST_LEN);
      else if (wr_cnt != '0)
        wr_cnt <= wr_cnt - 1'b1;

      // CAS latency marker
      rd_dly <= {rd_dly[`SDRAM_CL-2:0], rd_i};

      if (rd_dly[`SDRAM_CL-1])
        rd_cnt <= BCNT_W'(`SDRAM_BURST_LEN);
      else if (rd_cnt != '0)
        rd_cnt <= rd_cnt - 1'b1;
    end
  end

  assign sdram_dq_o   = wr_buf[`SDRAM_DQ_W-1:0];
  assign sdram_dqoe_o = |wr_cnt;
  assign rd_data_o    = sdram_dq_i;
  assign rd_valid_o   = |rd_cnt;

endmodule

// ==== sdram_sched_top.sv ====
////////////////////
// Single-port SDRAM command scheduler
// Client side takes level requests and returns a one-cycle ready
// SDRAM side drives commands and a burst of four words
////////////////////

`timescale 1ns/1ns
`include "sdram_sched_cfg.svh"

module sdram_sched_top (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic                         rd_req_i,
  input  logic                         wr_req_i,
  input  sdram_sched_pkg::ba_t         ba_i,
  input  sdram_sched_pkg::row_t        row_i,
  input  sdram_sched_pkg::col_t        col_i,
  input  sdram_sched_pkg::burst_t      wr_data_i,
  output logic                         rd_rdy_o,
  output logic                         wr_rdy_o,
  output sdram_sched_pkg::dq_t         rd_data_o,
  output logic                         rd_valid_o,
  output sdram_sched_pkg::sdram_cmd_e  sdram_cmd_o,
  output sdram_sched_pkg::ba_t         sdram_ba_o,
  output sdram_sched_pkg::sdram_addr_t sdram_addr_o,
  output sdram_sched_pkg::dq_t         sdram_dq_o,
  output logic                         sdram_dqoe_o,
  input  sdram_sched_pkg::dq_t         sdram_dq_i
);

  localparam int BANKS = 1 << `SDRAM_BA_W;

  // FSM strobes
  logic                 act;
  logic                 pre;
  logic                 pre_all;
  logic                 ref_cmd;
  logic                 rd;
  logic                 wr;
  sdram_sched_pkg::ba_t cmd_ba;

  // Status back to the FSM
  logic [BANKS-1:0] rcd_done;
  logic [BANKS-1:0] rp_done;
  logic [BANKS-1:0] ras_done;
  logic             rfc_done;
  logic             burst_done;
  logic             row_hit;
  logic             bank_idle;
  logic             all_idle;
  logic             refresh_pending;

  sdram_sched_fsm i_fsm (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .rd_req_i          (rd_req_i),
    .wr_req_i          (wr_req_i),
    .req_ba_i          (ba_i),
    .req_row_i         (row_i),
    .req_col_i         (col_i),
    .row_hit_i         (row_hit),
    .bank_idle_i       (bank_idle),
    .all_idle_i        (all_idle),
    .rcd_done_i        (rcd_done),
    .rp_done_i         (rp_done),
    .ras_done_i        (ras_done),
    .rfc_done_i        (rfc_done),
    .burst_done_i      (burst_done),
    .refresh_pending_i (refresh_pending),
    .act_o             (act),
    .pre_o             (pre),
    .pre_all_o         (pre_all),
    .ref_o             (ref_cmd),
    .rd_o              (rd),
    .wr_o              (wr),
    .cmd_ba_o          (cmd_ba),
    .rd_rdy_o          (rd_rdy_o),
    .wr_rdy_o          (wr_rdy_o),
    .sdram_cmd_o       (sdram_cmd_o),
    .sdram_ba_o        (sdram_ba_o),
    .sdram_addr_o      (sdram_addr_o)
  );

  sdram_bank_timers i_timers (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .act_i        (act),
    .pre_i        (pre),
    .pre_all_i    (pre_all),
    .ref_i        (ref_cmd),
    .rd_i         (rd),
    .wr_i         (wr),
    .cmd_ba_i     (cmd_ba),
    .rcd_done_o   (rcd_done),
    .rp_done_o    (rp_done),
    .ras_done_o   (ras_done),
    .rfc_done_o   (rfc_done),
    .burst_done_o (burst_done)
  );

  sdram_bank_table i_bank_table (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .act_i       (act),
    .pre_i       (pre),
    .pre_all_i   (pre_all),
    .cmd_ba_i    (cmd_ba),
    .cmd_row_i   (row_i),
    .req_ba_i    (ba_i),
    .req_row_i   (row_i),
    .row_hit_o   (row_hit),
    .bank_idle_o (bank_idle),
    .all_idle_o  (all_idle)
  );

  sdram_refresh_timer i_refresh (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .ref_issued_i      (ref_cmd),
    .refresh_pending_o (refresh_pending)
  );

  sdram_data_path i_data_path (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .rd_i         (rd),
    .wr_i         (wr),
    .wr_data_i    (wr_data_i),
    .sdram_dq_i   (sdram_dq_i),
    .sdram_dq_o   (sdram_dq_o),
    .sdram_dqoe_o (sdram_dqoe_o),
    .rd_data_o    (rd_data_o),
    .rd_valid_o   (rd_valid_o)
  );

endmodule

// ==== tb_sdram_sched.sv ====
////////////////////
// Testbench for the single-port SDRAM command scheduler
// Random writes and reads against a behavioral SDRAM model
// The monitor checks data, row policy, timing and refresh each cycle
////////////////////

`timescale 1ns/1ns
`include "sdram_sched_cfg.svh"

module tb_sdram_sched;

  localparam int BANKS       = 1 << `SDRAM_BA_W;
  localparam int BL          = `SDRAM_BURST_LEN;
  localparam int DQ          = `SDRAM_DQ_W;
  localparam int KEY_W       = `SDRAM_BA_W + `SDRAM_ROW_W + `SDRAM_COL_W;
  localparam int NTRANS      = 40;
  localparam int TIMEOUT_CYC = 40 * NTRANS + 3 * `SDRAM_T_REFI;

  logic                         clk_i;
  logic                         rst_ni;
  logic                         rd_req_i;
  logic                         wr_req_i;
  sdram_sched_pkg::ba_t         ba_i;
  sdram_sched_pkg::row_t        row_i;
  sdram_sched_pkg::col_t        col_i;
  sdram_sched_pkg::burst_t      wr_data_i;
  logic                         rd_rdy_o;
  logic                         wr_rdy_o;
  sdram_sched_pkg::dq_t         rd_data_o;
  logic                         rd_valid_o;
  sdram_sched_pkg::sdram_cmd_e  sdram_cmd_o;
  sdram_sched_pkg::ba_t         sdram_ba_o;
  sdram_sched_pkg::sdram_addr_t sdram_addr_o;
  sdram_sched_pkg::dq_t         sdram_dq_o;
  logic                         sdram_dqoe_o;
  sdram_sched_pkg::dq_t         sdram_dq_i = '0;

  // Next word the model puts on DQ
  sdram_sched_pkg::dq_t dq_next = '0;

  // Expected contents from the stimulus, and what the model saw on the bus
  sdram_sched_pkg::burst_t exp_mem [logic [KEY_W-1:0]];
  sdram_sched_pkg::burst_t mem [logic [KEY_W-1:0]];
  logic [KEY_W-1:0]        written [$];

  int mismatch_cnt = 0;
  int rule_cnt     = 0;
  int cyc          = 0;
  int timeout_cnt  = 0;
  int n_ref        = 0;

  sdram_sched_top i_sdram_sched_top (.*);

  initial clk_i = 1'b0;
  always #20 clk_i = ~clk_i;

  function automatic logic [KEY_W-1:0] addr_key(input sdram_sched_pkg::ba_t  ba,
                                                input sdram_sched_pkg::row_t row,
                                                input sdram_sched_pkg::col_t col);
    return {ba, row, col};
  endfunction

  task automatic value_mismatch(input string msg);
    mismatch_cnt++;
    $display("MISMATCH at %0t ns: %s", $time, msg);
  endtask

  task automatic rule_broken(input string msg);
    rule_cnt++;
    $display("Error at %0t ns: %s", $time, msg);
  endtask

  ////////////////////
  // SDRAM model and checks
  ////////////////////
  always @(posedge clk_i)
  begin
    int  c;
    int  b;
    int  k;
    logic [KEY_W-1:0]               key;
    sdram_sched_pkg::sdram_cmd_e    cmd;
    static logic [BANKS-1:0]        bank_open = '0;
    static sdram_sched_pkg::row_t   open_row [BANKS];
    static int                      last_act [BANKS] = '{default: -100};
    static int                      last_pre [BANKS] = '{default: -100};
    static int                      wr_end [BANKS] = '{default: -100};
    static int                      last_ref = -100;
    static int                      ref_base = 0;
    static int                      rd_start = -100;
    static int                      wr_start = -100;
    static sdram_sched_pkg::burst_t rd_exp;
    static sdram_sched_pkg::burst_t rd_drive;
    static sdram_sched_pkg::burst_t wr_exp;
    static sdram_sched_pkg::burst_t wr_cap;
    static logic [KEY_W-1:0]        wr_key;
    static logic                    in_req = 1'b0;
    static logic                    req_hit = 1'b0;
    static logic                    act_seen = 1'b0;
    static logic                    close_seen = 1'b0;

    c   = cyc;
    cmd = sdram_cmd_o;
    b   = int'(sdram_ba_o);
    if (rst_ni)
    begin
      if (cmd != sdram_sched_pkg::CMD_NOP)
        assert (c - last_ref >= `SDRAM_T_RFC) else rule_broken("command too soon after REF");

      case (cmd)
        sdram_sched_pkg::CMD_ACT:
        begin
          assert (!bank_open[b]) else rule_broken("ACT to a bank that is already open");
          assert (c - last_pre[b] >= `SDRAM_T_RP) else rule_broken("PRE to ACT too short");
          bank_open[b] = 1'b1;
          open_row[b]  = sdram_addr_o;
          last_act[b]  = c;
          act_seen     = act_seen | in_req;
        end
        sdram_sched_pkg::CMD_PRE:
        begin
          for (k = 0; k < BANKS; k++)
          begin
            if (sdram_addr_o[10] || k == b)
            begin
              if (bank_open[k])
              begin
                assert (c - last_act[k] >= `SDRAM_T_RAS) else rule_broken("ACT to PRE too short");
                assert (c - wr_end[k] >= `SDRAM_T_WR) else rule_broken("write recovery too short");
              end
              bank_open[k] = 1'b0;
              last_pre[k]  = c;
            end
          end
          // Only a refresh may close the bank of a pending hit
          close_seen = close_seen | (in_req & sdram_addr_o[10]);
        end
        sdram_sched_pkg::CMD_REF:
        begin
          assert (bank_open == '0) else rule_broken("REF while a bank is open");
          assert (c - ref_base <= `SDRAM_T_REFI + 40) else rule_broken("refresh came too late");
          last_ref   = c;
          ref_base   = c;
          n_ref      = n_ref + 1;
          close_seen = close_seen | in_req;
        end
        sdram_sched_pkg::CMD_RD, sdram_sched_pkg::CMD_WR:
        begin
          assert (bank_open[b] && open_row[b] == row_i)
            else rule_broken("RD or WR to a bank not open on the requested row");
          assert (c - last_act[b] >= `SDRAM_T_RCD) else rule_broken("ACT to RD or WR too short");
          assert (sdram_ba_o == ba_i && sdram_addr_o[`SDRAM_COL_W-1:0] == col_i)
            else value_mismatch($sformatf("bank %0d col %h, expected bank %0d col %h",
                                          sdram_ba_o, sdram_addr_o, ba_i, col_i));
          key = addr_key(sdram_ba_o, open_row[b], sdram_addr_o[`SDRAM_COL_W-1:0]);
          if (cmd == sdram_sched_pkg::CMD_RD)
          begin
            assert (exp_mem.exists(key) && mem.exists(key))
              else rule_broken("read of an address that was never written");
            rd_start = c + `SDRAM_CL;
            rd_exp   = exp_mem.exists(key) ? exp_mem[key] : 'x;
            rd_drive = mem.exists(key) ? mem[key] : '0;
          end
          else
          begin
            wr_start  = c;
            wr_exp    = wr_data_i;
            wr_key    = key;
            wr_end[b] = c + BL - 1;
          end
        end
        default: ;
      endcase

      assert (rd_rdy_o == (cmd == sdram_sched_pkg::CMD_RD)) else rule_broken("rd_rdy_o without RD");
      assert (wr_rdy_o == (cmd == sdram_sched_pkg::CMD_WR)) else rule_broken("wr_rdy_o without WR");

      // Write burst on the bus
      k = c - wr_start;
      assert (sdram_dqoe_o == (k >= 0 && k < BL)) else rule_broken("wrong dqoe window");
      if (k >= 0 && k < BL)
      begin
        assert (sdram_dq_o === wr_exp[k*DQ +: DQ])
          else value_mismatch($sformatf("write word %0d is %h, expected %h",
                                        k, sdram_dq_o, wr_exp[k*DQ +: DQ]));
        wr_cap[k*DQ +: DQ] = sdram_dq_o;
        if (k == BL - 1)
          mem[wr_key] = wr_cap;
      end

      // Read burst back to the client
      k = c - rd_start;
      assert (rd_valid_o == (k >= 0 && k < BL)) else rule_broken("wrong rd_valid_o window");
      if (k >= 0 && k < BL)
      begin
        assert (rd_data_o === rd_exp[k*DQ +: DQ])
          else value_mismatch($sformatf("read word %0d is %h, expected %h",
                                        k, rd_data_o, rd_exp[k*DQ +: DQ]));
      end

      // Device drives DQ CL cycles after RD
      k = c + 1 - rd_start;
      if (k >= 0 && k < BL)
        dq_next = rd_drive[k*DQ +: DQ];
      else
        dq_next = '0;

      // Hit requests must not see an ACT
      if (in_req && (rd_rdy_o || wr_rdy_o))
      begin
        if (req_hit && !close_seen)
        begin
          assert (!act_seen) else rule_broken("row hit served with an ACT");
        end
        in_req = 1'b0;
      end
      else if (!in_req && (rd_req_i || wr_req_i))
      begin
        in_req     = 1'b1;
        req_hit    = bank_open[ba_i] && open_row[ba_i] == row_i;
        act_seen   = 1'b0;
        close_seen = 1'b0;
      end
    end
    cyc = cyc + 1;
  end

  // Model drives DQ on the falling edge
  always @(negedge clk_i)
    sdram_dq_i = dq_next;

  always @(posedge clk_i)
  begin
    timeout_cnt = timeout_cnt + 1;
    if (timeout_cnt > TIMEOUT_CYC)
    begin
      $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYC);
      $display("Error counts: %0d value mismatches, %0d rule violations, %0d refreshes seen",
               mismatch_cnt, rule_cnt, n_ref);
      $display("Done: errors found");
      $finish;
    end
  end

  ////////////////////
  // Stimulus
  ////////////////////
  task automatic do_request(input logic                    is_rd,
                            input sdram_sched_pkg::ba_t    ba,
                            input sdram_sched_pkg::row_t   row,
                            input sdram_sched_pkg::col_t   col,
                            input sdram_sched_pkg::burst_t data);
    @(negedge clk_i);
    rd_req_i  = is_rd;
    wr_req_i  = ~is_rd;
    ba_i      = ba;
    row_i     = row;
    col_i     = col;
    wr_data_i = data;
    do
      @(negedge clk_i);
    while (!(rd_rdy_o || wr_rdy_o));
  endtask

  task automatic idle_cycles(input int n);
    @(negedge clk_i);
    rd_req_i = 1'b0;
    wr_req_i = 1'b0;
    repeat (n) @(negedge clk_i);
  endtask

  initial
  begin
    int                      idx;
    logic [KEY_W-1:0]        key;
    sdram_sched_pkg::ba_t    ba;
    sdram_sched_pkg::row_t   row;
    sdram_sched_pkg::col_t   col;
    sdram_sched_pkg::burst_t data;

    void'($urandom(32'ha2140c64));
    rst_ni    = 1'b0;
    rd_req_i  = 1'b0;
    wr_req_i  = 1'b0;
    ba_i      = '0;
    row_i     = '0;
    col_i     = '0;
    wr_data_i = '0;
    repeat (4) @(negedge clk_i);
    assert (sdram_cmd_o == sdram_sched_pkg::CMD_NOP && !rd_rdy_o && !wr_rdy_o &&
            !rd_valid_o && !sdram_dqoe_o)
      else rule_broken("outputs not idle after reset");
    rst_ni = 1'b1;

    for (int i = 0; i < NTRANS; i++)
    begin
      // Few rows per bank so hits and misses both occur
      if (i < 8 || written.size() == 0 || $urandom % 2 == 0)
      begin
        ba   = sdram_sched_pkg::ba_t'($urandom % BANKS);
        row  = sdram_sched_pkg::row_t'(($urandom % 3) * 37);
        col  = sdram_sched_pkg::col_t'(($urandom % 4) * BL);
        data = {$urandom, $urandom};
        key  = addr_key(ba, row, col);
        exp_mem[key] = data;
        written.push_back(key);
        do_request(1'b0, ba, row, col, data);
      end
      else
      begin
        idx = $urandom % written.size();
        {ba, row, col} = written[idx];
        do_request(1'b1, ba, row, col, '0);
      end
      idx = $urandom % 25;
      if (idx > 0)
        idle_cycles(idx);
    end
    idle_cycles(30);

    assert (n_ref >= cyc / `SDRAM_T_REFI - 1) else rule_broken("too few refreshes");
    $display("Error counts: %0d value mismatches, %0d rule violations, %0d refreshes seen",
             mismatch_cnt, rule_cnt, n_ref);
    if (mismatch_cnt + rule_cnt == 0)
      $display("Done: no errors");
    else
      $display("Done: errors found");
    $finish;
  end

endmodule

// ==== compile.f ====
+incdir+.
sdram_sched_pkg.sv
sdram_bank_timers.sv
sdram_bank_table.sv
sdram_refresh_timer.sv
sdram_sched_fsm.sv
sdram_data_path.sv
sdram_sched_top.sv
tb_sdram_sched.sv

// ==== Bender.yml ====
package:
  name: sdram_sched

sources:
  - include_dirs:
      - .
    files:
      - sdram_sched_pkg.sv
      - sdram_bank_timers.sv
      - sdram_bank_table.sv
      - sdram_refresh_timer.sv
      - sdram_sched_fsm.sv
      - sdram_data_path.sv
      - sdram_sched_top.sv
      - target: test
        files:
          - tb_sdram_sched.sv
